// File: common/rename_pkg.sv
package rename_pkg;

    // ********************
    // register spaces

    localparam int ARCH_REGS = 32;              // table resets to identity over these
    localparam int AREG_W    = 5;
    localparam int PREG_W    = 6;

    // defaults for the top level parameters
    localparam int GROUP_W_DEF  = 4;            // ops renamed per cycle
    localparam int NUM_PREG_DEF = 64;           // power of two, free list wraps on it

    // ********************
    // reorder buffer

    localparam int ROB_W = 5;                   // index only, dir bit travels beside it

    // ********************
    // register numbers

    typedef logic [AREG_W-1:0] areg_t;
    typedef logic [PREG_W-1:0] preg_t;

endpackage

// File: design/rename_table.sv
`timescale 1ns/100ps

module rename_table
    import rename_pkg::*;
#(
    parameter int GROUP_W = GROUP_W_DEF
) (
    input  logic               clk,
    input  logic               arst_n,
    // group read
    input  areg_t              rs1_areg [GROUP_W],
    input  areg_t              rs2_areg [GROUP_W],
    input  areg_t              rd_areg  [GROUP_W],
    output preg_t              rs1_preg [GROUP_W],
    output preg_t              rs2_preg [GROUP_W],
    output preg_t              rd_preg  [GROUP_W],
    // group write
    input  logic [GROUP_W-1:0] wr_en,
    input  areg_t              wr_areg  [GROUP_W],
    input  preg_t              wr_preg  [GROUP_W]
);

    preg_t map_q [ARCH_REGS];   // speculative arch -> phys

    // ********************
    // update

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int a = 0; a < ARCH_REGS; a++) begin
                map_q[a] <= preg_t'(a);     // identity
            end
        end else begin
            for (int w = 0; w < GROUP_W; w++) begin
                if (wr_en[w]) begin
                    map_q[wr_areg[w]] <= wr_preg[w];
                end
            end
        end
    end

    // ********************
    // lookup, no bypass of this cycle's writes

    for (genvar i = 0; i < GROUP_W; i++) begin : g_read
        assign rs1_preg[i] = map_q[rs1_areg[i]];
        assign rs2_preg[i] = map_q[rs2_areg[i]];
        assign rd_preg[i]  = map_q[rd_areg[i]];
    end

    // stage must keep only the youngest writer of each rd
    for (genvar i = 0; i < GROUP_W; i++) begin : g_chk_i
        for (genvar j = i + 1; j < GROUP_W; j++) begin : g_chk_j
            a_wr_unique: assert property (
                @(posedge clk) disable iff (!arst_n)
                !(wr_en[i] && wr_en[j] && (wr_areg[i] == wr_areg[j]))
            );
        end
    end

endmodule

// File: freelist/freelist.sv
`timescale 1ns/100ps

module freelist
    import rename_pkg::*;
#(
    parameter  int GROUP_W  = GROUP_W_DEF,
    parameter  int NUM_PREG = NUM_PREG_DEF,
    localparam int NUM_W    = $clog2(GROUP_W + 1)
) (
    input  logic               clk,
    input  logic               arst_n,
    // allocate
    input  logic [NUM_W-1:0]   alloc_num,
    input  logic               alloc_take,
    output preg_t              free_preg [GROUP_W],
    output logic               full,
    // commit release
    input  logic [GROUP_W-1:0] release_en,
    input  preg_t              release_preg [GROUP_W]
);

    localparam int PTR_W     = $clog2(NUM_PREG);
    localparam int CNT_W     = $clog2(NUM_PREG + 1);
    localparam int INIT_FREE = NUM_PREG - ARCH_REGS;

    preg_t            queue_q [NUM_PREG];
    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;
    logic [CNT_W-1:0] count_q;

    logic [NUM_W-1:0] rel_off [GROUP_W];    // compacted slot of each release
    logic [NUM_W-1:0] rel_num;
    logic [NUM_W-1:0] take_num;

    // ********************
    // release compaction

    always_comb begin
        rel_num = '0;
        for (int i = 0; i < GROUP_W; i++) begin
            rel_off[i] = rel_num;
            rel_num    = rel_num + NUM_W'(release_en[i]);
        end
    end

    assign take_num = alloc_take ? alloc_num : '0;

    // head window seen by the stage
    for (genvar k = 0; k < GROUP_W; k++) begin : g_head
        assign free_preg[k] = queue_q[head_q + PTR_W'(k)];
    end

    assign full = count_q < CNT_W'(alloc_num);  // group asks for more than is left

    // ********************
    // pointers and count

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head_q  <= '0;
            tail_q  <= PTR_W'(INIT_FREE);
            count_q <= CNT_W'(INIT_FREE);
        end else begin
            head_q  <= head_q + PTR_W'(take_num);
            tail_q  <= tail_q + PTR_W'(rel_num);
            count_q <= count_q + CNT_W'(rel_num) - CNT_W'(take_num);
        end
    end

    // entries 0..INIT_FREE-1 start as the regs above the arch space
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int e = 0; e < NUM_PREG; e++) begin
                queue_q[e] <= preg_t'(ARCH_REGS + e);
            end
        end else begin
            for (int i = 0; i < GROUP_W; i++) begin
                if (release_en[i]) begin
                    queue_q[tail_q + PTR_W'(rel_off[i])] <= release_preg[i];
                end
            end
        end
    end

    // ********************
    // checks

    // more frees than regs means a double release from commit
    a_count_range: assert property (
        @(posedge clk) disable iff (!arst_n)
        count_q <= CNT_W'(NUM_PREG)
    );

    a_no_take_full: assert property (
        @(posedge clk) disable iff (!arst_n)
        alloc_take |-> !full
    );

endmodule

// File: rename/rename_stage.sv
`timescale 1ns/100ps

module rename_stage
    import rename_pkg::*;
#(
    parameter  int GROUP_W = GROUP_W_DEF,
    localparam int NUM_W   = $clog2(GROUP_W + 1)
) (
    input  logic               clk,
    input  logic               arst_n,
    // decoder
    input  logic [GROUP_W-1:0] op_valid,
    input  logic [GROUP_W-1:0] op_we,
    input  areg_t              op_rd  [GROUP_W],
    input  areg_t              op_rs1 [GROUP_W],
    input  areg_t              op_rs2 [GROUP_W],
    input  logic               stall,
    input  logic               redirect,
    input  logic [ROB_W-1:0]   rob_tail_idx,
    input  logic               rob_tail_dir,
    // rename table
    output areg_t              rs1_areg [GROUP_W],
    output areg_t              rs2_areg [GROUP_W],
    output areg_t              rd_areg  [GROUP_W],
    input  preg_t              rs1_preg [GROUP_W],
    input  preg_t              rs2_preg [GROUP_W],
    input  preg_t              rd_preg  [GROUP_W],
    output logic [GROUP_W-1:0] wr_en,
    output areg_t              wr_areg  [GROUP_W],
    output preg_t              wr_preg  [GROUP_W],
    // free list
    output logic [NUM_W-1:0]   alloc_num,
    output logic               alloc_take,
    input  preg_t              free_preg [GROUP_W],
    input  logic               full,
    // dispatch
    output logic [GROUP_W-1:0] dis_valid,
    output logic [GROUP_W-1:0] dis_we,
    output areg_t              dis_rd      [GROUP_W],
    output preg_t              dis_prd     [GROUP_W],
    output preg_t              dis_prs1    [GROUP_W],
    output preg_t              dis_prs2    [GROUP_W],
    output preg_t              dis_old_prd [GROUP_W],
    output logic [ROB_W-1:0]   dis_rob_idx [GROUP_W],
    output logic [GROUP_W-1:0] dis_rob_dir,
    output logic [NUM_W-1:0]   valid_num
);

    localparam int IDX_W = (GROUP_W > 1) ? $clog2(GROUP_W) : 1;
    localparam int SUM_W = ROB_W + 1;

    logic               accept;
    logic [GROUP_W-1:0] rd_en;
    logic [GROUP_W-1:0] last_wr;                // youngest writer of its rd
    logic [NUM_W-1:0]   alloc_off [GROUP_W];
    logic [NUM_W-1:0]   valid_off [GROUP_W];
    logic [GROUP_W-1:0] raw_rs1   [GROUP_W];    // [consumer][producer]
    logic [GROUP_W-1:0] raw_rs2   [GROUP_W];
    logic [GROUP_W-1:0] waw       [GROUP_W];
    preg_t              prd       [GROUP_W];
    preg_t              prs1      [GROUP_W];
    preg_t              prs2      [GROUP_W];
    preg_t              old_prd   [GROUP_W];
    logic [ROB_W-1:0]   rob_idx   [GROUP_W];
    logic [GROUP_W-1:0] rob_dir;

    assign rd_en      = op_valid & op_we;
    assign accept     = ~stall & ~full & ~redirect;
    assign alloc_take = accept;

    // ********************
    // prefix counts

    always_comb begin
        alloc_num = '0;
        valid_num = '0;
        for (int i = 0; i < GROUP_W; i++) begin
            alloc_off[i] = alloc_num;           // writers below slot i
            valid_off[i] = valid_num;
            alloc_num    = alloc_num + NUM_W'(rd_en[i]);
            valid_num    = valid_num + NUM_W'(op_valid[i]);
        end
    end

    // ********************
    // dependency matrices, lower slot is older

    always_comb begin
        for (int i = 0; i < GROUP_W; i++) begin
            for (int j = 0; j < GROUP_W; j++) begin
                raw_rs1[i][j] = (j < i) && rd_en[j] && (op_rs1[i] == op_rd[j]);
                raw_rs2[i][j] = (j < i) && rd_en[j] && (op_rs2[i] == op_rd[j]);
                waw[i][j]     = (j != i) && rd_en[i] && rd_en[j] && (op_rd[i] == op_rd[j]);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < GROUP_W; i++) begin
            prd[i] = rd_en[i] ? free_preg[alloc_off[i][IDX_W-1:0]] : '0;
        end
        for (int i = 0; i < GROUP_W; i++) begin
            prs1[i]    = rs1_preg[i];
            prs2[i]    = rs2_preg[i];
            old_prd[i] = rd_preg[i];
            // ascending scan, nearest older match ends up on top
            for (int j = 0; j < i; j++) begin
                if (raw_rs1[i][j]) begin
                    prs1[i] = prd[j];
                end
                if (raw_rs2[i][j]) begin
                    prs2[i] = prd[j];
                end
                if (waw[i][j]) begin
                    old_prd[i] = prd[j];
                end
            end
            if (!rd_en[i]) begin
                old_prd[i] = '0;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < GROUP_W; i++) begin
            last_wr[i] = rd_en[i];
            for (int j = i + 1; j < GROUP_W; j++) begin
                if (waw[i][j]) begin
                    last_wr[i] = 1'b0;          // overwritten later in the group
                end
            end
        end
    end

    // ********************
    // rob index and wrap

    always_comb begin
        logic [SUM_W-1:0] rob_sum;
        for (int i = 0; i < GROUP_W; i++) begin
            rob_sum    = {1'b0, rob_tail_idx} + SUM_W'(valid_off[i]);
            rob_idx[i] = rob_sum[ROB_W-1:0];
            rob_dir[i] = rob_tail_dir ^ rob_sum[ROB_W];
        end
    end

    // table side
    assign rs1_areg = op_rs1;
    assign rs2_areg = op_rs2;
    assign rd_areg  = op_rd;
    assign wr_areg  = op_rd;
    assign wr_preg  = prd;
    assign wr_en    = {GROUP_W{accept}} & last_wr;

    // ********************
    // dispatch register

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dis_valid <= '0;
            dis_we    <= '0;
        end else if (redirect) begin
            dis_valid <= '0;
            dis_we    <= '0;
        end else if (accept) begin
            dis_valid <= op_valid;
            dis_we    <= rd_en;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dis_rd      <= op_rd;
            dis_prd     <= prd;
            dis_prs1    <= prs1;
            dis_prs2    <= prs2;
            dis_old_prd <= old_prd;
            dis_rob_idx <= rob_idx;
            dis_rob_dir <= rob_dir;
        end
    end

endmodule

// File: design/rename_top.sv
`timescale 1ns/100ps

module rename_top
    import rename_pkg::*;
#(
    parameter  int GROUP_W  = GROUP_W_DEF,
    parameter  int NUM_PREG = NUM_PREG_DEF,
    localparam int NUM_W    = $clog2(GROUP_W + 1)
) (
    input  logic               clk,
    input  logic               arst_n,
    // decoder
    input  logic [GROUP_W-1:0] op_valid,
    input  logic [GROUP_W-1:0] op_we,
    input  areg_t              op_rd  [GROUP_W],
    input  areg_t              op_rs1 [GROUP_W],
    input  areg_t              op_rs2 [GROUP_W],
    input  logic               stall,
    input  logic               redirect,
    input  logic [ROB_W-1:0]   rob_tail_idx,
    input  logic               rob_tail_dir,
    // dispatch
    output logic [GROUP_W-1:0] dis_valid,
    output logic [GROUP_W-1:0] dis_we,
    output areg_t              dis_rd      [GROUP_W],
    output preg_t              dis_prd     [GROUP_W],
    output preg_t              dis_prs1    [GROUP_W],
    output preg_t              dis_prs2    [GROUP_W],
    output preg_t              dis_old_prd [GROUP_W],
    output logic [ROB_W-1:0]   dis_rob_idx [GROUP_W],
    output logic [GROUP_W-1:0] dis_rob_dir,
    output logic [NUM_W-1:0]   valid_num,
    output logic               full,
    // commit
    input  logic [GROUP_W-1:0] commit_free,
    input  preg_t              commit_old_prd [GROUP_W]
);

    areg_t              rs1_areg  [GROUP_W];
    areg_t              rs2_areg  [GROUP_W];
    areg_t              rd_areg   [GROUP_W];
    preg_t              rs1_preg  [GROUP_W];
    preg_t              rs2_preg  [GROUP_W];
    preg_t              rd_preg   [GROUP_W];
    logic [GROUP_W-1:0] wr_en;
    areg_t              wr_areg   [GROUP_W];
    preg_t              wr_preg   [GROUP_W];
    logic [NUM_W-1:0]   alloc_num;
    logic               alloc_take;
    preg_t              free_preg [GROUP_W];

    rename_stage #(.GROUP_W(GROUP_W)) rename_stage_i (.*);

    rename_table #(.GROUP_W(GROUP_W)) rename_table_i (.*);

    freelist #(
        .GROUP_W  (GROUP_W),
        .NUM_PREG (NUM_PREG)
    ) freelist_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .alloc_num    (alloc_num),
        .alloc_take   (alloc_take),
        .free_preg    (free_preg),
        .full         (full),
        .release_en   (commit_free),      // committed ops hand back their old mapping
        .release_preg (commit_old_prd)
    );

endmodule

// File: verif/rename_tb_table.svh
    // one row per cycle, slot 0 sits in the low byte of rd, rs1 and rs2
    // columns: valid, we, rd, rs1, rs2, ctrl {random, full, redirect, stall},
    // rob tail index, rob tail dir, number of commits released in that cycle

    task automatic fill_table();
        // ********************
        // identity start, allocation order, RAW and WAW inside a group
        add_row(4'b1111, 4'b1111, 32'h04030201, 32'h08070605, 32'h0c0b0a09, 4'b0000, 0, 0, 0);
        add_row(4'b1111, 4'b0101, 32'h14131211, 32'h1d1e1f00, 32'h15161718, 4'b0000, 4, 0, 0);
        add_row(4'b1111, 4'b1111, 32'h07050605, 32'h05060511, 32'h06010203, 4'b0000, 8, 0, 0);
        add_row(4'b0011, 4'b0001, 32'h00000009, 32'h00000505, 32'h00000706, 4'b0000, 12, 0, 0);
        // rob wrap
        add_row(4'b1111, 4'b0000, 32'h00000000, 32'h0d0c0b0a, 32'h11100f0e, 4'b0000, 30, 0, 0);
        add_row(4'b1010, 4'b1000, 32'h1f000000, 32'h1f000900, 32'h00000500, 4'b0000, 31, 1, 0);
        // redirect, then stall
        add_row(4'b1111, 4'b1111, 32'h04030201, 32'h08070605, 32'h0c0b0a09, 4'b0010, 0, 0, 0);
        add_row(4'b1111, 4'b1111, 32'h0b0a0908, 32'h01020304, 32'h08090a0b, 4'b0000, 2, 1, 0);
        add_row(4'b1111, 4'b1111, 32'h0f0e0d0c, 32'h0c0d0e0f, 32'h0b0a0908, 4'b0001, 6, 1, 0);
        add_row(4'b1111, 4'b1111, 32'h0f0e0d0c, 32'h0c0d0e0f, 32'h0b0a0908, 4'b0000, 6, 1, 0);
        // ********************
        // drain the free list
        add_row(4'b1111, 4'b1111, 32'h13121110, 32'h10101010, 32'h12111010, 4'b0000, 10, 1, 0);
        add_row(4'b1111, 4'b1111, 32'h11111111, 32'h11111111, 32'h00000000, 4'b0000, 14, 1, 0);
        add_row(4'b1111, 4'b1110, 32'h15141311, 32'h11111111, 32'h13131313, 4'b0000, 18, 1, 0);
        add_row(4'b1111, 4'b1111, 32'h04030201, 32'h01010101, 32'h02020202, 4'b0100, 22, 1, 0);
        add_row(4'b1111, 4'b1111, 32'h04030201, 32'h01010101, 32'h02020202, 4'b0100, 22, 1, 4);
        add_row(4'b1111, 4'b1111, 32'h04030201, 32'h01010101, 32'h02020202, 4'b0000, 22, 1, 0);
        add_row(4'b0011, 4'b0010, 32'h00001e00, 32'h00001e1e, 32'h00000000, 4'b0000, 26, 1, 0);
        add_row(4'b1111, 4'b0000, 32'h00000000, 32'h1e030201, 32'h11131517, 4'b0000, 28, 1, 4);
        add_row(4'b1111, 4'b0001, 32'h00000005, 32'h05050505, 32'h00000000, 4'b0000, 0, 0, 4);
        // ********************
        // random registers with steady commit
        add_row(4'b1111, 4'b1111, 32'h0, 32'h0, 32'h0, 4'b1000, 3, 0, 4);
        add_row(4'b1111, 4'b1111, 32'h0, 32'h0, 32'h0, 4'b1000, 7, 0, 4);
        add_row(4'b1111, 4'b1111, 32'h0, 32'h0, 32'h0, 4'b1000, 11, 0, 4);
        add_row(4'b1111, 4'b0111, 32'h0, 32'h0, 32'h0, 4'b1000, 15, 0, 4);
        add_row(4'b1111, 4'b1111, 32'h0, 32'h0, 32'h0, 4'b1000, 19, 0, 4);
        add_row(4'b1011, 4'b1111, 32'h0, 32'h0, 32'h0, 4'b1000, 23, 0, 4);
        add_row(4'b1111, 4'b1101, 32'h0, 32'h0, 32'h0, 4'b1000, 26, 0, 4);
        add_row(4'b1111, 4'b1111, 32'h0, 32'h0, 32'h0, 4'b1010, 29, 0, 4);
        add_row(4'b1111, 4'b1111, 32'h0, 32'h0, 32'h0, 4'b1000, 29, 0, 4);
        add_row(4'b1111, 4'b1111, 32'h0, 32'h0, 32'h0, 4'b1000, 30, 1, 4);
        add_row(4'b1111, 4'b1111, 32'h07060504, 32'h03020100, 32'h1f1e1d1c, 4'b0000, 2, 0, 0);
    endtask

// File: verif/rename_tb.sv
`timescale 1ns/100ps

module rename_tb
    import rename_pkg::*;
();

    localparam int GROUP_W  = GROUP_W_DEF;
    localparam int NUM_W    = $clog2(GROUP_W + 1);
    localparam int MAX_ROWS = 64;

    logic               clk = 1'b0;
    logic               arst_n = 1'b0;
    logic [GROUP_W-1:0] op_valid;
    logic [GROUP_W-1:0] op_we;
    areg_t              op_rd  [GROUP_W];
    areg_t              op_rs1 [GROUP_W];
    areg_t              op_rs2 [GROUP_W];
    logic               stall;
    logic               redirect;
    logic [ROB_W-1:0]   rob_tail_idx;
    logic               rob_tail_dir;
    logic [GROUP_W-1:0] commit_free;
    preg_t              commit_old_prd [GROUP_W];
    logic [GROUP_W-1:0] dis_valid;
    logic [GROUP_W-1:0] dis_we;
    areg_t              dis_rd      [GROUP_W];
    preg_t              dis_prd     [GROUP_W];
    preg_t              dis_prs1    [GROUP_W];
    preg_t              dis_prs2    [GROUP_W];
    preg_t              dis_old_prd [GROUP_W];
    logic [ROB_W-1:0]   dis_rob_idx [GROUP_W];
    logic [GROUP_W-1:0] dis_rob_dir;
    logic [NUM_W-1:0]   valid_num;
    logic               full;

    // reference model
    preg_t              ref_map [ARCH_REGS];
    preg_t              free_q [$];
    preg_t              commit_q [$];      // replaced regs waiting for commit
    logic [GROUP_W-1:0] exp_valid = '0;
    logic [GROUP_W-1:0] exp_we = '0;
    areg_t              exp_rd   [GROUP_W];
    preg_t              exp_prd  [GROUP_W];
    preg_t              exp_prs1 [GROUP_W];
    preg_t              exp_prs2 [GROUP_W];
    preg_t              exp_old  [GROUP_W];
    logic [ROB_W-1:0]   exp_idx  [GROUP_W];
    logic [GROUP_W-1:0] exp_dir;

    logic [GROUP_W-1:0] row_valid   [MAX_ROWS];
    logic [GROUP_W-1:0] row_we      [MAX_ROWS];
    logic [31:0]        row_rd      [MAX_ROWS];
    logic [31:0]        row_rs1     [MAX_ROWS];
    logic [31:0]        row_rs2     [MAX_ROWS];
    logic [3:0]         row_ctrl    [MAX_ROWS];
    logic [ROB_W-1:0]   row_tail    [MAX_ROWS];
    logic               row_dir     [MAX_ROWS];
    int                 row_commits [MAX_ROWS];
    int                 num_rows = 0;
    integer             seed = 32'hc76ef58e;
    int                 cycles = 0;

    rename_top #(.GROUP_W(GROUP_W), .NUM_PREG(NUM_PREG_DEF)) rename_top_i (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= num_rows * 4 + 100) begin
            $display("timeout: the table loop did not finish within %0d cycles", cycles);
            $display("ERRORS FOUND");
            $fatal(1, "run stopped by timeout");
        end
    end

    // ********************
    // checks

    task automatic fail_run();
        $display("ERRORS FOUND");
        $fatal(1, "run stopped at first mismatch");
    endtask

    task automatic check_preg(input preg_t got, input preg_t exp, input string what);
        if (got !== exp) begin
            $display("** Error at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
            fail_run();
        end
    endtask

    task automatic check_areg(input areg_t got, input areg_t exp, input string what);
        if (got !== exp) begin
            $display("** Error at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
            fail_run();
        end
    endtask

    task automatic check_rob(input logic [ROB_W-1:0] got, input logic [ROB_W-1:0] exp,
                             input string what);
        if (got !== exp) begin
            $display("** Error at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
            fail_run();
        end
    endtask

    task automatic check_count(input logic [NUM_W-1:0] got, input logic [NUM_W-1:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("** Error at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
            fail_run();
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("** Error at time %0t: %s is %b, expected %b", $time, what, got, exp);
            fail_run();
        end
    endtask

    task automatic check_outputs();
        for (int i = 0; i < GROUP_W; i++) begin
            check_bit(dis_valid[i], exp_valid[i], $sformatf("dis_valid[%0d]", i));
            check_bit(dis_we[i], exp_we[i], $sformatf("dis_we[%0d]", i));
            if (exp_valid[i]) begin
                check_areg(dis_rd[i], exp_rd[i], $sformatf("dis_rd[%0d]", i));
                check_preg(dis_prs1[i], exp_prs1[i], $sformatf("dis_prs1[%0d]", i));
                check_preg(dis_prs2[i], exp_prs2[i], $sformatf("dis_prs2[%0d]", i));
                check_rob(dis_rob_idx[i], exp_idx[i], $sformatf("dis_rob_idx[%0d]", i));
                check_bit(dis_rob_dir[i], exp_dir[i], $sformatf("dis_rob_dir[%0d]", i));
            end
            if (exp_we[i]) begin
                check_preg(dis_prd[i], exp_prd[i], $sformatf("dis_prd[%0d]", i));
                check_preg(dis_old_prd[i], exp_old[i], $sformatf("dis_old_prd[%0d]", i));
            end
        end
    endtask

    // ********************
    // model of one accepted group

    function automatic int nearest_writer(input int slot, input areg_t areg);
        int found;
        found = -1;
        for (int j = slot - 1; j >= 0 && found < 0; j--) begin
            if (op_valid[j] && op_we[j] && op_rd[j] == areg) begin
                found = j;
            end
        end
        return found;
    endfunction

    task automatic resolve_group();
        preg_t new_prd [GROUP_W];
        int    k;
        int    n;
        int    pos;
        k = 0;
        pos = 0;
        for (int i = 0; i < GROUP_W; i++) begin
            new_prd[i] = '0;
            if (op_valid[i] && op_we[i]) begin
                new_prd[i] = free_q[k];     // k-th head entry
                k++;
            end
        end
        for (int i = 0; i < GROUP_W; i++) begin
            n = nearest_writer(i, op_rs1[i]);
            exp_prs1[i] = (n >= 0) ? new_prd[n] : ref_map[op_rs1[i]];
            n = nearest_writer(i, op_rs2[i]);
            exp_prs2[i] = (n >= 0) ? new_prd[n] : ref_map[op_rs2[i]];
            n = nearest_writer(i, op_rd[i]);
            exp_old[i] = (n >= 0) ? new_prd[n] : ref_map[op_rd[i]];
            exp_prd[i] = new_prd[i];
            exp_rd[i] = op_rd[i];
            {exp_dir[i], exp_idx[i]} = {rob_tail_dir, rob_tail_idx} + 6'(pos);  // carry flips dir
            pos = pos + int'(op_valid[i]);
        end
        for (int i = 0; i < GROUP_W; i++) begin
            if (op_valid[i] && op_we[i]) begin
                ref_map[op_rd[i]] = new_prd[i];
                void'(free_q.pop_front());
                commit_q.push_back(exp_old[i]);
            end
        end
        exp_valid = op_valid;
        exp_we    = op_valid & op_we;
    endtask

    // ********************
    // stimulus table

    task automatic add_row(input logic [3:0] valid, input logic [3:0] we,
                           input logic [31:0] rd, input logic [31:0] rs1,
                           input logic [31:0] rs2, input logic [3:0] ctrl,
                           input int tail, input int dir, input int commits);
        row_valid[num_rows]   = valid;
        row_we[num_rows]      = we;
        row_rd[num_rows]      = rd;
        row_rs1[num_rows]     = rs1;
        row_rs2[num_rows]     = rs2;
        row_ctrl[num_rows]    = ctrl;
        row_tail[num_rows]    = ROB_W'(tail);
        row_dir[num_rows]     = 1'(dir);
        row_commits[num_rows] = commits;
        if (ctrl[3]) begin
            row_rd[num_rows]  = $random(seed) & 32'h1f1f1f1f;
            row_rs1[num_rows] = $random(seed) & 32'h1f1f1f1f;
            row_rs2[num_rows] = $random(seed) & 32'h1f1f1f1f;
        end
        num_rows++;
    endtask

    `include "rename_tb_table.svh"

    task automatic drive_row(input int r);
        op_valid     = row_valid[r];
        op_we        = row_we[r];
        stall        = row_ctrl[r][0];
        redirect     = row_ctrl[r][1];
        rob_tail_idx = row_tail[r];
        rob_tail_dir = row_dir[r];
        commit_free  = '0;
        for (int i = 0; i < GROUP_W; i++) begin
            op_rd[i]  = areg_t'(row_rd[r][8*i +: 8]);
            op_rs1[i] = areg_t'(row_rs1[r][8*i +: 8]);
            op_rs2[i] = areg_t'(row_rs2[r][8*i +: 8]);
            commit_old_prd[i] = '0;
            if (i < row_commits[r] && commit_q.size() > 0) begin
                commit_free[i]    = 1'b1;       // oldest replaced regs retire first
                commit_old_prd[i] = commit_q.pop_front();
            end
        end
    endtask

    initial begin
        logic starved;
        op_valid     = '0;
        op_we        = '0;
        stall        = 1'b0;
        redirect     = 1'b0;
        rob_tail_idx = '0;
        rob_tail_dir = 1'b0;
        commit_free  = '0;
        for (int i = 0; i < GROUP_W; i++) begin
            op_rd[i]          = '0;
            op_rs1[i]         = '0;
            op_rs2[i]         = '0;
            commit_old_prd[i] = '0;
        end
        for (int a = 0; a < ARCH_REGS; a++) begin
            ref_map[a] = preg_t'(a);
        end
        for (int p = ARCH_REGS; p < NUM_PREG_DEF; p++) begin
            free_q.push_back(preg_t'(p));
        end
        fill_table();
        repeat (10) @(posedge clk);
        #1 arst_n = 1'b1;

        for (int r = 0; r < num_rows; r++) begin
            @(posedge clk);
            #1;
            check_outputs();
            drive_row(r);
            #4;
            check_bit(full, row_ctrl[r][2], "full");
            check_count(valid_num, NUM_W'($countones(op_valid)), "valid_num");
            starved = free_q.size() < $countones(op_valid & op_we);
            if (redirect) begin
                exp_valid = '0;
                exp_we    = '0;
            end else if (!stall && !starved) begin
                resolve_group();
            end
            for (int i = 0; i < GROUP_W; i++) begin
                if (commit_free[i]) begin
                    free_q.push_back(commit_old_prd[i]);
                end
            end
        end
        @(posedge clk);
        #1;
        check_outputs();

        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: project.f
+incdir+verif
common/rename_pkg.sv
design/rename_table.sv
freelist/freelist.sv
rename/rename_stage.sv
design/rename_top.sv
verif/rename_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the rename testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --top-module rename_tb -f project.f -o rename_sim

./obj_dir/rename_sim | tee sim.log

if grep -qx "NO ERRORS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
